// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - src/isa_pkg.sv
  - src/uarch_pkg.sv
  - src/decode_conds.sv
  - src/decode_data.sv
  - src/decode_ldst.sv
  - src/decode_mul.sv
  - src/core_decode.sv
  - src/decode_stage.sv
  - target: test
    files:
      - bench/decode_tb.sv

// ==== bench/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb;

	logic clk, rst_n, insn_valid, stall;
	logic [31:0] insn;
	logic [3:0] flags;
	logic out_valid, execute, undefined, branch, ldst, mul;
	logic writeback, update_flags, restore_spsr, uses_rn;
	logic [3:0] alu_op, rd, rn, snd_r, mul_ra;
	logic snd_is_imm, snd_shift_by_reg, mul_accumulate;
	logic [11:0] snd_imm;
	logic [1:0] snd_shift;
	logic [4:0] snd_shift_imm;
	logic [31:0] branch_offset;
	logic ldst_load, ldst_byte, ldst_pre, ldst_up, ldst_base_wb;
	logic [15:0] ldst_reglist;

	logic [15:0] lfsr = 16'd43889;
	int errors = 0;
	string current_test;

	decode_stage decode_stage_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// even codes test a flag rule, odd codes invert it
	function automatic logic cond_passes(input logic [3:0] c, input logic [3:0] f);
		logic n, z, cf, v, base;
		{n, z, cf, v} = f;
		case (c[3:1])
			3'd0: base = z;
			3'd1: base = cf;
			3'd2: base = n;
			3'd3: base = v;
			3'd4: base = cf && !z;
			3'd5: base = n == v;
			3'd6: base = !z && n == v;
			default: base = 1'b1;
		endcase
		return c[0] ? !base : base;
	endfunction

	task automatic expect_eq(input string field, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s %s expected %0h actual %0h", current_test, field, exp, act);
			errors++;
		end
	endtask

	// present one word, then wait for the registered decode
	task automatic issue(input logic [31:0] w, input logic [3:0] f);
		int cycles;
		cycles = 0;
		@(posedge clk);
		insn <= w;
		flags <= f;
		insn_valid <= 1'b1;
		@(posedge clk);
		insn_valid <= 1'b0;
		@(negedge clk);
		while (!out_valid && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (!out_valid) begin
			$display("%s: out_valid never rose for insn %h", current_test, w);
			errors++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	task automatic test_conditions();
		logic [3:0] f;
		current_test = "conditions";
		for (int c = 0; c < 15; c++) begin
			f = rand_bits(4);
			issue({c[3:0], 28'h3A01000}, f); // mov r1, #0
			expect_eq("execute", cond_passes(c[3:0], f), execute);
			expect_eq("undefined", 0, undefined);
		end
		issue({4'hF, 28'h3A01000}, 4'h0);
		expect_eq("nv undefined", 1, undefined);
		expect_eq("nv execute", 0, execute);
	endtask

	task automatic test_data_proc();
		logic [3:0] opc, rn_f, rd_f, rot;
		logic [7:0] imm8;
		logic s, cmp;
		current_test = "data_proc";
		for (int i = 0; i < 10; i++) begin
			opc = rand_bits(4);
			rn_f = rand_bits(4);
			rd_f = rand_bits(4);
			rot = rand_bits(4);
			imm8 = rand_bits(8);
			s = rand_bits(1);
			cmp = opc[3:2] == 2'b10; // tst teq cmp cmn
			if (cmp)
				s = 1'b1; // s clear here would be a psr transfer
			issue({4'hE, 3'b001, opc, s, rn_f, rd_f, rot, imm8}, 4'h0);
			expect_eq("alu_op", opc, alu_op);
			expect_eq("rd", rd_f, rd);
			expect_eq("rn", rn_f, rn);
			expect_eq("uses_rn", !(opc == 4'hD || opc == 4'hF), uses_rn);
			expect_eq("snd_is_imm", 1, snd_is_imm);
			expect_eq("snd_imm", imm8, snd_imm);
			expect_eq("snd_shift", 3, snd_shift); // ror
			expect_eq("snd_shift_imm", rot * 2, snd_shift_imm);
			expect_eq("writeback", !cmp, writeback);
			expect_eq("update_flags", cmp ? 1'b1 : s, update_flags);
			expect_eq("undefined", 0, undefined);
		end
		issue({4'hE, 8'h1B, 4'h0, 4'hF, 12'h00E}, 4'h0); // movs pc, lr
		expect_eq("movs restore_spsr", 1, restore_spsr);
		expect_eq("movs snd_is_imm", 0, snd_is_imm);
		expect_eq("movs snd_r", 14, snd_r);
		expect_eq("movs undefined", 0, undefined);
		issue({4'hE, 8'h08, 4'h1, 4'h2, 4'h4, 4'h1, 4'h3}, 4'h0); // add r2, r1, r3, lsl r4
		expect_eq("shift by reg", 1, snd_shift_by_reg);
		expect_eq("shift by reg kind", 0, snd_shift);
		expect_eq("shift by reg rm", 3, snd_r);
		expect_eq("shift by reg undefined", 0, undefined);
		issue({4'hE, 8'h08, 4'h1, 4'h2, 4'hF, 4'h1, 4'h3}, 4'h0); // add r2, r1, r3, lsl r15
		expect_eq("shift by r15 undefined", 1, undefined);
		expect_eq("shift by r15 execute", 0, execute);
	endtask

	task automatic test_branch();
		logic [23:0] off;
		logic link;
		current_test = "branch";
		for (int i = 0; i < 8; i++) begin
			off = rand_bits(24);
			link = (i == 0) ? 1'b1 : rand_bits(1);
			issue({4'hE, 3'b101, link, off}, 4'h0);
			expect_eq("branch", 1, branch);
			expect_eq("branch_offset", {{8{off[23]}}, off} << 2, branch_offset);
			expect_eq("writeback", link, writeback);
			if (link) begin
				expect_eq("link rd", 14, rd);
				expect_eq("link rn", 15, rn);
				expect_eq("link snd_imm", 4, snd_imm);
				expect_eq("link alu_op", 4'h2, alu_op);
			end
		end
	endtask

	task automatic test_mul_ldst();
		logic [3:0] rd_f, ra_f, rs_f, rm_f, rn_f;
		logic [11:0] off;
		logic [15:0] list;
		logic acc, s, u;
		current_test = "mul_ldst";
		for (int i = 0; i < 4; i++) begin
			rd_f = rand_bits(3);
			rm_f = {1'b1, 3'(rand_bits(3))}; // upper half keeps rm apart from rd
			ra_f = rand_bits(4);
			rs_f = rand_bits(4);
			acc = rand_bits(1);
			s = rand_bits(1);
			issue({4'hE, 6'b0, acc, s, rd_f, ra_f, rs_f, 4'b1001, rm_f}, 4'h0);
			expect_eq("mul", 1, mul);
			expect_eq("mul rd", rd_f, rd);
			expect_eq("mul rs", rs_f, rn);
			expect_eq("mul rm", rm_f, snd_r);
			expect_eq("mul_ra", ra_f, mul_ra);
			expect_eq("mul_accumulate", acc, mul_accumulate);
			expect_eq("mul update_flags", s, update_flags);
		end
		issue({4'hE, 8'h00, 4'h5, 4'h0, 4'h2, 4'b1001, 4'h5}, 4'h0);
		expect_eq("mul rd=rm undefined", 1, undefined);
		rn_f = rand_bits(4);
		off = rand_bits(12);
		u = rand_bits(1);
		issue({4'hE, 3'b010, 1'b1, u, 3'b001, rn_f, 4'h3, off}, 4'h0); // ldr r3, [rn, #off]
		expect_eq("load ldst", 1, ldst);
		expect_eq("load writeback", 1, writeback);
		expect_eq("load rn", rn_f, rn);
		expect_eq("load snd_is_imm", 1, snd_is_imm);
		expect_eq("load offset", off, snd_imm);
		expect_eq("load alu_op", u ? 4'h4 : 4'h2, alu_op);
		expect_eq("load pre", 1, ldst_pre);
		expect_eq("load up", u, ldst_up);
		expect_eq("load byte", 0, ldst_byte);
		issue({4'hE, 3'b010, 5'b01100, 4'h1, 4'h3, off}, 4'h0); // strb r3, [r1], #off
		expect_eq("post store base_wb", 1, ldst_base_wb);
		expect_eq("post store load", 0, ldst_load);
		expect_eq("post store byte", 1, ldst_byte);
		expect_eq("post store pre", 0, ldst_pre);
		list = rand_bits(16) | 16'h0001;
		issue({4'hE, 3'b100, 5'b01001, 4'hD, list}, 4'h0); // ldmia sp, {list}
		expect_eq("ldm reglist", list, ldst_reglist);
		expect_eq("ldm step", 4, snd_imm);
		expect_eq("ldm ldst", 1, ldst);
	endtask

	task automatic test_unsupported();
		logic [31:0] words [3];
		current_test = "unsupported";
		words[0] = 32'hEE000010; // coprocessor register transfer
		words[1] = 32'hE1D000B0; // ldrh
		words[2] = 32'hEF000000; // swi
		foreach (words[i]) begin
			issue(words[i], 4'h0);
			expect_eq("undefined", 1, undefined);
			expect_eq("execute", 0, execute);
		end
	endtask

	task automatic test_stall();
		current_test = "stall";
		@(posedge clk);
		insn <= {4'hE, 8'h3A, 4'h0, 4'h1, 12'h011}; // mov r1, #0x11
		insn_valid <= 1'b1;
		@(negedge clk);
		expect_eq("out_valid before accept", 0, out_valid);
		@(posedge clk);
		stall <= 1'b1;
		insn <= {4'hE, 8'h3A, 4'h0, 4'h2, 12'h022}; // mov r2, #0x22
		repeat (4) begin
			@(negedge clk);
			expect_eq("out_valid held", 1, out_valid);
			expect_eq("rd held", 1, rd);
			expect_eq("snd_imm held", 12'h011, snd_imm);
		end
		@(posedge clk);
		stall <= 1'b0;
		@(posedge clk);
		insn_valid <= 1'b0; // this edge takes the second word
		@(negedge clk);
		expect_eq("rd after stall", 2, rd);
		expect_eq("snd_imm after stall", 12'h022, snd_imm);
	endtask

	initial begin
		rst_n = 1'b0;
		insn_valid = 1'b0;
		insn = '0;
		flags = '0;
		stall = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		current_test = "reset";
		expect_eq("out_valid", 0, out_valid);
		expect_eq("strobes", 0, {execute, branch, ldst, mul, writeback, update_flags});
		test_conditions();
		test_data_proc();
		test_branch();
		test_mul_ldst();
		test_unsupported();
		test_stall();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
src/isa_pkg.sv
src/uarch_pkg.sv
src/decode_conds.sv
src/decode_data.sv
src/decode_ldst.sv
src/decode_mul.sv
src/core_decode.sv
src/decode_stage.sv
bench/decode_tb.sv

// ==== src/core_decode.sv ====
`timescale 1ns/1ps

module core_decode (
	input  isa_pkg::word                        insn,
	input  logic [3:0]                          flags, // n z c v
	output logic                                execute, undefined, branch, ldst, mul,
	output logic                                writeback, update_flags, restore_spsr,
	output isa_pkg::alu_op                      alu_op,
	output isa_pkg::reg_num                     rd, rn,
	output logic                                uses_rn,
	output logic                                snd_is_imm,
	output logic [uarch_pkg::imm_width-1:0]     snd_imm,
	output isa_pkg::reg_num                     snd_r,
	output logic                                snd_shift_by_reg,
	output uarch_pkg::shift_kind                snd_shift,
	output logic [uarch_pkg::shamt_width-1:0]   snd_shift_imm,
	output logic [31:0]                         branch_offset,
	output logic                                ldst_load, ldst_byte, ldst_pre, ldst_up,
	output logic                                ldst_base_wb,
	output logic [uarch_pkg::reglist_width-1:0] ldst_reglist,
	output logic                                mul_accumulate,
	output isa_pkg::reg_num                     mul_ra
);

	logic [7:0] op;
	logic cond_execute, cond_undefined, is_mult, dp_ext, dp_psr;

	isa_pkg::alu_op data_op;
	isa_pkg::reg_num data_rd, data_rn, data_snd_r, data_snd_rs;
	logic data_uses_rn, data_writeback, data_update_flags, data_restore_spsr;
	logic data_snd_is_imm, data_snd_shift_by_reg, data_undefined;
	logic [uarch_pkg::imm_width-1:0] data_snd_imm;
	uarch_pkg::shift_kind data_snd_shift;
	logic [uarch_pkg::shamt_width-1:0] data_snd_shift_imm;

	isa_pkg::reg_num ls_rn, ls_rd, ls_off_r;
	logic ls_off_is_imm, ls_restore_spsr;
	logic [uarch_pkg::imm_width-1:0] ls_off_imm;
	uarch_pkg::shift_kind ls_off_shift;
	logic [uarch_pkg::shamt_width-1:0] ls_off_shift_imm;

	isa_pkg::reg_num mul_rd, mul_rn, mul_rs, mul_rm;
	logic mul_s, mul_undefined;

	assign op      = insn[isa_pkg::op_msb:isa_pkg::op_lsb];
	assign is_mult = op ==? isa_pkg::group_ldst_mult;
	assign dp_ext  = !insn[25] && insn[7] && insn[4]; // mul, swap and halfword space
	assign dp_psr  = insn[24:23] == 2'b10 && !insn[20]; // mrs/msr

	assign branch_offset = {{(30 - uarch_pkg::offset_width){insn[uarch_pkg::offset_width-1]}},
		insn[uarch_pkg::offset_width-1:0], 2'b00};

	decode_conds conds (
		.cond(insn[isa_pkg::cond_msb:isa_pkg::cond_lsb]),
		.flags,
		.execute(cond_execute),
		.undefined(cond_undefined)
	);

	decode_data group_data (
		.insn, .op(data_op), .rd(data_rd), .rn(data_rn), .uses_rn(data_uses_rn),
		.writeback(data_writeback), .update_flags(data_update_flags),
		.restore_spsr(data_restore_spsr), .snd_is_imm(data_snd_is_imm),
		.snd_imm(data_snd_imm), .snd_r(data_snd_r), .snd_rs(data_snd_rs),
		.snd_shift_by_reg(data_snd_shift_by_reg), .snd_shift(data_snd_shift),
		.snd_shift_imm(data_snd_shift_imm), .undefined(data_undefined)
	);

	decode_ldst group_ldst (
		.insn, .multiple(is_mult), .load(ldst_load), .byte_size(ldst_byte),
		.pre_index(ldst_pre), .up(ldst_up), .base_writeback(ldst_base_wb),
		.rn(ls_rn), .rd(ls_rd), .offset_is_imm(ls_off_is_imm), .offset_imm(ls_off_imm),
		.offset_r(ls_off_r), .offset_shift(ls_off_shift),
		.offset_shift_imm(ls_off_shift_imm), .reglist(ldst_reglist),
		.restore_spsr(ls_restore_spsr)
	);

	decode_mul group_mul (
		.insn, .rd(mul_rd), .rn(mul_rn), .rs(mul_rs), .rm(mul_rm),
		.accumulate(mul_accumulate), .update_flags(mul_s), .undefined(mul_undefined)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// group select, order matters since mul sits inside the alu space
	always_comb begin
		branch = 1'b0;
		ldst = 1'b0;
		mul = 1'b0;
		undefined = cond_undefined;
		writeback = 1'b0;
		update_flags = 1'b0;
		restore_spsr = 1'b0;
		alu_op = data_op;
		rd = data_rd;
		rn = data_rn;
		uses_rn = 1'b1;
		snd_is_imm = 1'b1;
		snd_imm = data_snd_imm;
		snd_r = data_snd_r;
		snd_shift_by_reg = 1'b0;
		snd_shift = uarch_pkg::lsl;
		snd_shift_imm = '0;
		mul_ra = mul_rn;

		if (op ==? isa_pkg::group_b) begin
			branch = 1'b1;
			if (insn[isa_pkg::link_bit]) begin
				alu_op = isa_pkg::sub_op; // lr = pc - 4
				rd = isa_pkg::r14;
				rn = isa_pkg::r15;
				snd_imm = uarch_pkg::link_adjust;
				writeback = 1'b1;
			end
		end else if (op ==? isa_pkg::group_mul && insn[7:4] == 4'b1001) begin
			mul = 1'b1;
			rd = mul_rd;
			rn = mul_rs;
			snd_is_imm = 1'b0;
			snd_r = mul_rm;
			writeback = 1'b1;
			update_flags = mul_s;
			undefined |= mul_undefined;
		end else if (op ==? isa_pkg::group_alu && !dp_ext && !dp_psr) begin
			uses_rn = data_uses_rn;
			writeback = data_writeback;
			update_flags = data_update_flags;
			restore_spsr = data_restore_spsr;
			snd_is_imm = data_snd_is_imm;
			snd_shift_by_reg = data_snd_shift_by_reg;
			snd_shift = data_snd_shift;
			snd_shift_imm = data_snd_shift_imm;
			mul_ra = data_snd_rs; // third read port serves rs on reg shifts
			undefined |= data_undefined;
		end else if (op ==? isa_pkg::group_ldst_single_imm
				|| op ==? isa_pkg::group_ldst_single_reg || is_mult) begin
			ldst = 1'b1;
			alu_op = ldst_up ? isa_pkg::add_op : isa_pkg::sub_op;
			rd = ls_rd;
			rn = ls_rn;
			writeback = ldst_load || ldst_base_wb;
			restore_spsr = ls_restore_spsr;
			snd_is_imm = ls_off_is_imm;
			snd_imm = is_mult ? uarch_pkg::ldm_step : ls_off_imm;
			snd_r = ls_off_r;
			snd_shift = ls_off_shift;
			snd_shift_imm = ls_off_shift_imm;
			undefined |= !ls_off_is_imm && insn[4]; // media space
		end else begin
			undefined = 1'b1; // misc ldst, swap, coprocessor, psr, swi
		end

		execute = cond_execute && !undefined;
		if (undefined) begin
			branch = 1'b0;
			ldst = 1'b0;
			mul = 1'b0;
			writeback = 1'b0;
			update_flags = 1'b0;
			restore_spsr = 1'b0;
		end
	end

	assert final ($isunknown(insn) || undefined || $onehot0({branch, ldst, mul}))
		else $error("more than one instruction group selected");

endmodule

// ==== src/decode_conds.sv ====
`timescale 1ns/1ps

module decode_conds (
	input  isa_pkg::cond_code cond,
	input  logic [3:0]        flags,
	output logic              execute,
	output logic              undefined
);

	logic n, z, c, v;

	assign {n, z, c, v} = flags;
	assign undefined = cond == isa_pkg::nv;

	always_comb begin
		unique case (cond)
			isa_pkg::eq: execute = z;
			isa_pkg::ne: execute = !z;
			isa_pkg::cs: execute = c;
			isa_pkg::cc: execute = !c;
			isa_pkg::mi: execute = n;
			isa_pkg::pl: execute = !n;
			isa_pkg::vs: execute = v;
			isa_pkg::vc: execute = !v;
			isa_pkg::hi: execute = c && !z;
			isa_pkg::ls: execute = !c || z;
			isa_pkg::ge: execute = n == v;
			isa_pkg::lt: execute = n != v;
			isa_pkg::gt: execute = !z && (n == v);
			isa_pkg::le: execute = z || (n != v);
			isa_pkg::al: execute = 1'b1;
			default:     execute = 1'b0; // nv
		endcase
	end

	assert final ($isunknown({cond, flags}) || !(execute && undefined))
		else $error("condition both executes and is undefined");

endmodule

// ==== src/decode_data.sv ====
`timescale 1ns/1ps

module decode_data (
	input  isa_pkg::insn_word_u               insn,
	output isa_pkg::alu_op                    op,
	output isa_pkg::reg_num                   rd,
	output isa_pkg::reg_num                   rn,
	output logic                              uses_rn,
	output logic                              writeback,
	output logic                              update_flags,
	output logic                              restore_spsr,
	output logic                              snd_is_imm,
	output logic [uarch_pkg::imm_width-1:0]   snd_imm,
	output isa_pkg::reg_num                   snd_r,
	output isa_pkg::reg_num                   snd_rs,
	output logic                              snd_shift_by_reg,
	output uarch_pkg::shift_kind              snd_shift,
	output logic [uarch_pkg::shamt_width-1:0] snd_shift_imm,
	output logic                              undefined
);

	logic compare;

	assign op = insn.dp.opcode;
	assign rd = insn.dp.rd;
	assign rn = insn.dp.rn;

	assign compare = op inside {isa_pkg::tst_op, isa_pkg::teq_op,
		isa_pkg::cmp_op, isa_pkg::cmn_op};

	assign uses_rn      = !(op == isa_pkg::mov_op || op == isa_pkg::mvn_op);
	assign writeback    = !compare;
	assign update_flags = insn.dp.s || compare; // compares always set flags
	assign restore_spsr = insn.dp.s && !compare && rd == isa_pkg::r15; // movs pc, lr and friends

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand2: rotated 8-bit immediate or shifted rm
	assign snd_is_imm       = insn.dp.imm;
	assign snd_imm          = {4'b0, insn.dp.operand2[7:0]};
	assign snd_r            = insn.dp.operand2[3:0];
	assign snd_rs           = insn.dp.operand2[11:8];
	assign snd_shift_by_reg = !insn.dp.imm && insn.dp.operand2[4];

	always_comb begin
		if (insn.dp.imm) begin
			snd_shift     = uarch_pkg::ror;
			snd_shift_imm = {insn.dp.operand2[11:8], 1'b0}; // rotate by twice the field
		end else begin
			snd_shift     = insn.dp.operand2[6:5];
			snd_shift_imm = insn.dp.operand2[11:7];
		end
	end

	assign undefined = snd_shift_by_reg && (snd_rs == isa_pkg::r15 || snd_r == isa_pkg::r15);

endmodule

// ==== src/decode_ldst.sv ====
`timescale 1ns/1ps

module decode_ldst (
	input  isa_pkg::insn_word_u                 insn,
	input  logic                                multiple,
	output logic                                load,
	output logic                                byte_size,
	output logic                                pre_index,
	output logic                                up,
	output logic                                base_writeback,
	output isa_pkg::reg_num                     rn,
	output isa_pkg::reg_num                     rd,
	output logic                                offset_is_imm,
	output logic [uarch_pkg::imm_width-1:0]     offset_imm,
	output isa_pkg::reg_num                     offset_r,
	output uarch_pkg::shift_kind                offset_shift,
	output logic [uarch_pkg::shamt_width-1:0]   offset_shift_imm,
	output logic [uarch_pkg::reglist_width-1:0] reglist,
	output logic                                restore_spsr
);

	assign load           = insn.ldst.l;
	assign byte_size      = insn.ldst.b && !multiple; // b is the s bit on ldm/stm
	assign pre_index      = insn.ldst.p;
	assign up             = insn.ldst.u;
	assign base_writeback = insn.ldst.w || (!insn.ldst.p && !multiple); // post-index writes back
	assign rn             = insn.ldst.rn;
	assign rd             = insn.ldst.rd;

	assign offset_is_imm = multiple || !insn.ldst.cls[0];
	assign offset_imm    = insn.ldst.offset;
	assign offset_r      = insn.ldst.offset[3:0];

	always_comb begin
		if (offset_is_imm) begin
			offset_shift     = uarch_pkg::lsl;
			offset_shift_imm = '0;
		end else begin
			offset_shift     = insn.ldst.offset[6:5];
			offset_shift_imm = insn.ldst.offset[11:7];
		end
	end

	assign reglist = {insn.ldst.rd, insn.ldst.offset};

	// ldm with s and pc in the list returns from exception
	assign restore_spsr = multiple && insn.ldst.b && insn.ldst.l && reglist[15];

	assert final ($isunknown({multiple, reglist}) || !multiple || reglist != '0)
		else $error("ldm/stm with an empty register list");

endmodule

// ==== src/decode_mul.sv ====
`timescale 1ns/1ps

module decode_mul (
	input  isa_pkg::word    insn,
	output isa_pkg::reg_num rd,
	output isa_pkg::reg_num rn,
	output isa_pkg::reg_num rs,
	output isa_pkg::reg_num rm,
	output logic            accumulate,
	output logic            update_flags,
	output logic            undefined
);

	assign rd           = insn[19:16]; // swapped against data processing
	assign rn           = insn[15:12]; // accumulate operand
	assign rs           = insn[11:8];
	assign rm           = insn[3:0];
	assign accumulate   = insn[21];
	assign update_flags = insn[20];

	assign undefined = rd == isa_pkg::r15 || rd == rm;

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                insn_valid,
	input  isa_pkg::word                        insn,
	input  logic [3:0]                          flags, // n z c v
	input  logic                                stall,
	output logic                                out_valid,
	output logic                                execute, undefined, branch, ldst, mul,
	output logic                                writeback, update_flags, restore_spsr,
	output isa_pkg::alu_op                      alu_op,
	output isa_pkg::reg_num                     rd, rn,
	output logic                                uses_rn,
	output logic                                snd_is_imm,
	output logic [uarch_pkg::imm_width-1:0]     snd_imm,
	output isa_pkg::reg_num                     snd_r,
	output logic                                snd_shift_by_reg,
	output uarch_pkg::shift_kind                snd_shift,
	output logic [uarch_pkg::shamt_width-1:0]   snd_shift_imm,
	output logic [31:0]                         branch_offset,
	output logic                                ldst_load, ldst_byte, ldst_pre, ldst_up,
	output logic                                ldst_base_wb,
	output logic [uarch_pkg::reglist_width-1:0] ldst_reglist,
	output logic                                mul_accumulate,
	output isa_pkg::reg_num                     mul_ra
);

	logic execute_d, undefined_d, branch_d, ldst_d, mul_d;
	logic writeback_d, update_flags_d, restore_spsr_d, uses_rn_d;
	logic snd_is_imm_d, snd_shift_by_reg_d;
	logic ldst_load_d, ldst_byte_d, ldst_pre_d, ldst_up_d, ldst_base_wb_d, mul_accumulate_d;
	isa_pkg::alu_op alu_op_d;
	isa_pkg::reg_num rd_d, rn_d, snd_r_d, mul_ra_d;
	logic [uarch_pkg::imm_width-1:0] snd_imm_d;
	uarch_pkg::shift_kind snd_shift_d;
	logic [uarch_pkg::shamt_width-1:0] snd_shift_imm_d;
	logic [31:0] branch_offset_d;
	logic [uarch_pkg::reglist_width-1:0] ldst_reglist_d;

	logic [uarch_pkg::ctrl_width-1:0] ctrl_d, ctrl_q;

	core_decode decode (
		.insn, .flags,
		.execute(execute_d), .undefined(undefined_d), .branch(branch_d), .ldst(ldst_d),
		.mul(mul_d), .writeback(writeback_d), .update_flags(update_flags_d),
		.restore_spsr(restore_spsr_d), .alu_op(alu_op_d), .rd(rd_d), .rn(rn_d),
		.uses_rn(uses_rn_d), .snd_is_imm(snd_is_imm_d), .snd_imm(snd_imm_d),
		.snd_r(snd_r_d), .snd_shift_by_reg(snd_shift_by_reg_d), .snd_shift(snd_shift_d),
		.snd_shift_imm(snd_shift_imm_d), .branch_offset(branch_offset_d),
		.ldst_load(ldst_load_d), .ldst_byte(ldst_byte_d), .ldst_pre(ldst_pre_d),
		.ldst_up(ldst_up_d), .ldst_base_wb(ldst_base_wb_d), .ldst_reglist(ldst_reglist_d),
		.mul_accumulate(mul_accumulate_d), .mul_ra(mul_ra_d)
	);

	assign ctrl_d = {execute_d, undefined_d, branch_d, ldst_d, mul_d,
		writeback_d, update_flags_d, restore_spsr_d,
		alu_op_d, rd_d, rn_d, uses_rn_d,
		snd_is_imm_d, snd_imm_d, snd_r_d, snd_shift_by_reg_d, snd_shift_d, snd_shift_imm_d,
		branch_offset_d,
		ldst_load_d, ldst_byte_d, ldst_pre_d, ldst_up_d, ldst_base_wb_d, ldst_reglist_d,
		mul_accumulate_d, mul_ra_d};

	// stall freezes everything, upstream keeps the word until it drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			ctrl_q <= '0;
		end else if (!stall) begin
			out_valid <= insn_valid;
			if (insn_valid)
				ctrl_q <= ctrl_d;
		end
	end

	assign {execute, undefined, branch, ldst, mul,
		writeback, update_flags, restore_spsr,
		alu_op, rd, rn, uses_rn,
		snd_is_imm, snd_imm, snd_r, snd_shift_by_reg, snd_shift, snd_shift_imm,
		branch_offset,
		ldst_load, ldst_byte, ldst_pre, ldst_up, ldst_base_wb, ldst_reglist,
		mul_accumulate, mul_ra} = ctrl_q;

	assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(ctrl_q) && $stable(out_valid))
		else $error("decode outputs moved during stall");

endmodule

// ==== src/isa_pkg.sv ====
package isa_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;
	typedef logic [3:0]  cond_code;
	typedef logic [3:0]  alu_op;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// field positions
	localparam int cond_msb = 31;
	localparam int cond_lsb = 28;
	localparam int op_msb   = 27;
	localparam int op_lsb   = 20;
	localparam int link_bit = 24;

	// matched against insn[27:20]
	localparam logic [7:0] group_b               = 8'b101?????;
	localparam logic [7:0] group_mul             = 8'b000000??; // plus 1001 in bits 7..4
	localparam logic [7:0] group_alu             = 8'b00??????;
	localparam logic [7:0] group_ldst_single_imm = 8'b010?????;
	localparam logic [7:0] group_ldst_single_reg = 8'b011?????;
	localparam logic [7:0] group_ldst_mult       = 8'b100?????;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// condition codes
	localparam cond_code eq = 4'b0000;
	localparam cond_code ne = 4'b0001;
	localparam cond_code cs = 4'b0010;
	localparam cond_code cc = 4'b0011;
	localparam cond_code mi = 4'b0100;
	localparam cond_code pl = 4'b0101;
	localparam cond_code vs = 4'b0110;
	localparam cond_code vc = 4'b0111;
	localparam cond_code hi = 4'b1000;
	localparam cond_code ls = 4'b1001;
	localparam cond_code ge = 4'b1010;
	localparam cond_code lt = 4'b1011;
	localparam cond_code gt = 4'b1100;
	localparam cond_code le = 4'b1101;
	localparam cond_code al = 4'b1110;
	localparam cond_code nv = 4'b1111;

	// data-processing opcodes, bits 24..21
	localparam alu_op and_op = 4'b0000;
	localparam alu_op eor_op = 4'b0001;
	localparam alu_op sub_op = 4'b0010;
	localparam alu_op rsb_op = 4'b0011;
	localparam alu_op add_op = 4'b0100;
	localparam alu_op adc_op = 4'b0101;
	localparam alu_op sbc_op = 4'b0110;
	localparam alu_op rsc_op = 4'b0111;
	localparam alu_op tst_op = 4'b1000;
	localparam alu_op teq_op = 4'b1001;
	localparam alu_op cmp_op = 4'b1010;
	localparam alu_op cmn_op = 4'b1011;
	localparam alu_op orr_op = 4'b1100;
	localparam alu_op mov_op = 4'b1101;
	localparam alu_op bic_op = 4'b1110;
	localparam alu_op mvn_op = 4'b1111;

	localparam reg_num r14 = 4'd14; // link register
	localparam reg_num r15 = 4'd15; // pc

	// the same word seen as data processing or as single/multiple transfer
	typedef union packed {
		struct packed {
			cond_code    cond;
			logic [1:0]  cls;
			logic        imm;
			alu_op       opcode;
			logic        s;
			reg_num      rn;
			reg_num      rd;
			logic [11:0] operand2;
		} dp;
		struct packed {
			cond_code    cond;
			logic [2:0]  cls; // bit 25 set means register offset
			logic        p;
			logic        u;
			logic        b;   // s bit for ldm/stm
			logic        w;
			logic        l;
			reg_num      rn;
			reg_num      rd;
			logic [11:0] offset;
		} ldst;
	} insn_word_u;

endpackage

// ==== src/uarch_pkg.sv ====
package uarch_pkg;

	typedef logic [1:0] shift_kind;

	localparam shift_kind lsl = 2'b00;
	localparam shift_kind lsr = 2'b01;
	localparam shift_kind asr = 2'b10;
	localparam shift_kind ror = 2'b11;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control field widths
	localparam int imm_width     = 12;
	localparam int offset_width  = 24; // branch offset before extension
	localparam int reglist_width = 16;
	localparam int shamt_width   = 5;

	// immediates the decoder makes up on its own
	localparam logic [imm_width-1:0] link_adjust = 12'd4; // lr = pc - 4
	localparam logic [imm_width-1:0] ldm_step    = 12'd4; // one word per register

	// strobes, alu, second operand, branch, ldst, mul
	localparam int ctrl_width = 8
		+ 13
		+ (1 + imm_width + 4 + 1 + 2 + shamt_width)
		+ 32
		+ 5 + reglist_width
		+ 5;

endpackage
